/* cam_cfg_pkg.sv */
package cam_cfg_pkg;

	// ======================================================================
	// Bus timing and sensor addresses
	// ======================================================================

	// clk_25 cycles per SCCB tick, one tick is half an scl period
	localparam int SCCB_TICK_DIV = 128;

	typedef logic [7:0] byte_t;

	// Write address, read address has bit 0 set
	localparam byte_t SCCB_DEV_ADDR = 8'h60;
	// Sensor ID register
	localparam byte_t ID_SUB_ADDR = 8'h18;

	localparam int CFG_TABLE_LEN = 16;

	// ======================================================================
	// Command and state types
	// ======================================================================

	typedef enum logic [1:0] {
		SCCB_WR3,
		SCCB_WR2,
		SCCB_RD2
	} sccb_kind_t;

	typedef struct packed {
		sccb_kind_t kind;
		byte_t      sub_addr;
		byte_t      data;
	} sccb_cmd_t;

	typedef struct packed {
		byte_t sub_addr;
		byte_t data;
	} cfg_entry_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_CFG,
		SEQ_ID_ADDR,
		SEQ_ID_READ,
		SEQ_OVER
	} seq_state_t;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_START,
		PH_DEV,
		PH_SUB,
		PH_DATA,
		PH_READ,
		PH_STOP
	} sccb_phase_t;

endpackage

/* cam_cfg_rom.sv */
`timescale 1ns/1ps

module cam_cfg_rom (
	input  logic [3:0]              index,
	output cam_cfg_pkg::cfg_entry_t entry
);

	// Sensor setup table, sub-address then data
	always_comb
	begin
		case (index)
			// Soft reset of the register bank
			4'd0:
				entry = '{8'h12, 8'h80};
			4'd1:
				entry = '{8'h11, 8'h80};
			4'd2:
				entry = '{8'h6a, 8'h3e};
			4'd3:
				entry = '{8'h3b, 8'h09};
			4'd4:
				entry = '{8'h13, 8'he0};
			4'd5:
				entry = '{8'h01, 8'h80};
			4'd6:
				entry = '{8'h02, 8'h80};
			4'd7:
				entry = '{8'h00, 8'h00};
			4'd8:
				entry = '{8'h10, 8'h00};
			// AGC and AEC back on
			4'd9:
				entry = '{8'h13, 8'he5};
			4'd10:
				entry = '{8'h39, 8'h50};
			4'd11:
				entry = '{8'h38, 8'h93};
			4'd12:
				entry = '{8'h37, 8'h81};
			4'd13:
				entry = '{8'h35, 8'h91};
			4'd14:
				entry = '{8'h0e, 8'h20};
			default:
				entry = '{8'h1e, 8'h04};
		endcase
	end

endmodule

/* sccb_master.sv */
`timescale 1ns/1ps

module sccb_master (
	input  logic                   clk_25,
	input  logic                   rst,
	input  logic                   req,
	input  cam_cfg_pkg::sccb_cmd_t cmd,
	output logic                   done,
	output cam_cfg_pkg::byte_t     rd_data,
	output logic                   scl,
	inout  wire                    sda
);

	cam_cfg_pkg::sccb_phase_t phase;
	cam_cfg_pkg::sccb_phase_t phase_after;
	cam_cfg_pkg::sccb_cmd_t   cmd_q;
	cam_cfg_pkg::byte_t       tx_byte;
	cam_cfg_pkg::byte_t       rd_shift;
	logic [$clog2(cam_cfg_pkg::SCCB_TICK_DIV)-1:0] div_cnt;
	logic [4:0] slot;
	logic       tick;
	logic       phase_end;
	logic       sda_oe_next;
	logic       sda_out_next;
	logic       sda_oe;
	logic       sda_out;

	// ======================================================================
	// Tick divider, held in idle so each command starts on a full tick
	// ======================================================================

	assign tick = (phase != cam_cfg_pkg::PH_IDLE) &&
		(div_cnt == cam_cfg_pkg::SCCB_TICK_DIV - 1);

	always_ff @(posedge clk_25 or negedge rst)
	begin
		if (!rst)
			div_cnt <= '0;
		else if (phase == cam_cfg_pkg::PH_IDLE || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// ======================================================================
	// Phase sequencing
	// ======================================================================

	// Start and stop take two slots, each byte nine bits of two slots
	always_comb
	begin
		phase_end = 1'b0;
		phase_after = cam_cfg_pkg::PH_IDLE;
		case (phase)
			cam_cfg_pkg::PH_START:
			begin
				phase_end = (slot == 5'd1);
				phase_after = cam_cfg_pkg::PH_DEV;
			end
			cam_cfg_pkg::PH_DEV:
			begin
				phase_end = (slot == 5'd17);
				if (cmd_q.kind == cam_cfg_pkg::SCCB_RD2)
					phase_after = cam_cfg_pkg::PH_READ;
				else
					phase_after = cam_cfg_pkg::PH_SUB;
			end
			cam_cfg_pkg::PH_SUB:
			begin
				phase_end = (slot == 5'd17);
				if (cmd_q.kind == cam_cfg_pkg::SCCB_WR3)
					phase_after = cam_cfg_pkg::PH_DATA;
				else
					phase_after = cam_cfg_pkg::PH_STOP;
			end
			cam_cfg_pkg::PH_DATA, cam_cfg_pkg::PH_READ:
			begin
				phase_end = (slot == 5'd17);
				phase_after = cam_cfg_pkg::PH_STOP;
			end
			cam_cfg_pkg::PH_STOP:
			begin
				phase_end = (slot == 5'd1);
				phase_after = cam_cfg_pkg::PH_IDLE;
			end
			default:
			begin
				phase_end = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk_25 or negedge rst)
	begin
		if (!rst)
		begin
			phase <= cam_cfg_pkg::PH_IDLE;
			slot <= '0;
		end
		else if (phase == cam_cfg_pkg::PH_IDLE)
		begin
			slot <= '0;
			if (req)
				phase <= cam_cfg_pkg::PH_START;
		end
		else if (tick)
		begin
			if (phase_end)
			begin
				slot <= '0;
				phase <= phase_after;
			end
			else
				slot <= slot + 1'b1;
		end
	end

	// Last cycle of the stop phase
	assign done = tick && phase_end && (phase == cam_cfg_pkg::PH_STOP);

	// Command latch and read capture on rising scl
	always_ff @(posedge clk_25)
	begin
		if (phase == cam_cfg_pkg::PH_IDLE && req)
			cmd_q <= cmd;
		if (tick && phase == cam_cfg_pkg::PH_READ && !slot[0] && slot < 5'd16)
			rd_shift <= {rd_shift[6:0], sda};
		if (tick && phase == cam_cfg_pkg::PH_READ && phase_end)
			rd_data <= rd_shift;
	end

	// ======================================================================
	// Bus pins
	// ======================================================================

	// Odd slots are the high half of each bit
	assign scl = (phase == cam_cfg_pkg::PH_IDLE || phase == cam_cfg_pkg::PH_START) ?
		1'b1 : slot[0];

	always_comb
	begin
		case (phase)
			cam_cfg_pkg::PH_DEV:
				tx_byte = cam_cfg_pkg::SCCB_DEV_ADDR |
					{7'd0, cmd_q.kind == cam_cfg_pkg::SCCB_RD2};
			cam_cfg_pkg::PH_SUB:
				tx_byte = cmd_q.sub_addr;
			default:
				tx_byte = cmd_q.data;
		endcase
	end

	always_comb
	begin
		sda_oe_next = 1'b0;
		sda_out_next = 1'b1;
		case (phase)
			// Falls in the second slot with scl high
			cam_cfg_pkg::PH_START:
			begin
				sda_oe_next = 1'b1;
				sda_out_next = (slot == 5'd0);
			end
			// MSB first, ninth bit released
			cam_cfg_pkg::PH_DEV, cam_cfg_pkg::PH_SUB, cam_cfg_pkg::PH_DATA:
			begin
				sda_oe_next = (slot < 5'd16);
				sda_out_next = tx_byte[3'd7 - slot[3:1]];
			end
			// Low through the scl rise, high from mid slot
			cam_cfg_pkg::PH_STOP:
			begin
				sda_oe_next = 1'b1;
				sda_out_next = slot[0] && (div_cnt >= cam_cfg_pkg::SCCB_TICK_DIV / 2);
			end
			default:
			begin
				sda_oe_next = 1'b0;
			end
		endcase
	end

	// One cycle behind scl, so data moves only after scl has fallen
	always_ff @(posedge clk_25 or negedge rst)
	begin
		if (!rst)
		begin
			sda_oe <= 1'b0;
			sda_out <= 1'b1;
		end
		else
		begin
			sda_oe <= sda_oe_next;
			sda_out <= sda_out_next;
		end
	end

	assign sda = sda_oe ? sda_out : 1'bz;

endmodule

/* cam_cfg_sequencer.sv */
`timescale 1ns/1ps

module cam_cfg_sequencer (
	input  logic                    clk_25,
	input  logic                    rst,
	input  logic                    start_button,
	output logic                    req,
	output cam_cfg_pkg::sccb_cmd_t  cmd,
	input  logic                    done,
	input  cam_cfg_pkg::byte_t      rd_data,
	output logic [3:0]              index,
	input  cam_cfg_pkg::cfg_entry_t entry,
	output logic                    configure_over,
	output cam_cfg_pkg::byte_t      cam_id
);

	cam_cfg_pkg::seq_state_t state;
	logic button_q;
	logic start_edge;

	// ======================================================================
	// Start edge and run sequence
	// ======================================================================

	always_ff @(posedge clk_25 or negedge rst)
	begin
		if (!rst)
			button_q <= 1'b0;
		else
			button_q <= start_button;
	end

	assign start_edge = start_button && !button_q;

	always_ff @(posedge clk_25 or negedge rst)
	begin
		if (!rst)
		begin
			state <= cam_cfg_pkg::SEQ_IDLE;
			index <= '0;
			configure_over <= 1'b0;
			cam_id <= '0;
		end
		else
		begin
			case (state)
				cam_cfg_pkg::SEQ_IDLE:
				begin
					index <= '0;
					if (start_edge)
						state <= cam_cfg_pkg::SEQ_CFG;
				end
				// One table write per done
				cam_cfg_pkg::SEQ_CFG:
				begin
					if (done)
					begin
						if (index == cam_cfg_pkg::CFG_TABLE_LEN - 1)
						begin
							index <= '0;
							state <= cam_cfg_pkg::SEQ_ID_ADDR;
						end
						else
							index <= index + 1'b1;
					end
				end
				cam_cfg_pkg::SEQ_ID_ADDR:
				begin
					if (done)
						state <= cam_cfg_pkg::SEQ_ID_READ;
				end
				// configure_over stays set until reset
				cam_cfg_pkg::SEQ_ID_READ:
				begin
					if (done)
					begin
						cam_id <= rd_data;
						configure_over <= 1'b1;
						state <= cam_cfg_pkg::SEQ_OVER;
					end
				end
				default:
				begin
					state <= cam_cfg_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	// ======================================================================
	// Command to the SCCB master
	// ======================================================================

	assign req = (state == cam_cfg_pkg::SEQ_CFG) ||
		(state == cam_cfg_pkg::SEQ_ID_ADDR) ||
		(state == cam_cfg_pkg::SEQ_ID_READ);

	always_comb
	begin
		cmd.kind = cam_cfg_pkg::SCCB_WR3;
		cmd.sub_addr = entry.sub_addr;
		cmd.data = entry.data;
		case (state)
			cam_cfg_pkg::SEQ_ID_ADDR:
			begin
				cmd.kind = cam_cfg_pkg::SCCB_WR2;
				cmd.sub_addr = cam_cfg_pkg::ID_SUB_ADDR;
				cmd.data = '0;
			end
			// Address comes from the previous write
			cam_cfg_pkg::SEQ_ID_READ:
			begin
				cmd.kind = cam_cfg_pkg::SCCB_RD2;
				cmd.sub_addr = cam_cfg_pkg::ID_SUB_ADDR;
				cmd.data = '0;
			end
			default:
			begin
				cmd.kind = cam_cfg_pkg::SCCB_WR3;
			end
		endcase
	end

endmodule

/* camera_control.sv */
`timescale 1ns/1ps

module camera_control (
	input  logic               clk_25,
	input  logic               rst,
	input  logic               start_button,
	output logic               scl,
	inout  wire                sda,
	output logic               configure_over,
	output cam_cfg_pkg::byte_t cam_id
);

	cam_cfg_pkg::sccb_cmd_t  cmd;
	cam_cfg_pkg::cfg_entry_t entry;
	cam_cfg_pkg::byte_t      rd_data;
	logic [3:0] index;
	logic       req;
	logic       done;

	cam_cfg_sequencer u_sequencer (
		.clk_25         (clk_25),
		.rst            (rst),
		.start_button   (start_button),
		.req            (req),
		.cmd            (cmd),
		.done           (done),
		.rd_data        (rd_data),
		.index          (index),
		.entry          (entry),
		.configure_over (configure_over),
		.cam_id         (cam_id)
	);

	cam_cfg_rom u_rom (
		.index (index),
		.entry (entry)
	);

	sccb_master u_master (
		.clk_25  (clk_25),
		.rst     (rst),
		.req     (req),
		.cmd     (cmd),
		.done    (done),
		.rd_data (rd_data),
		.scl     (scl),
		.sda     (sda)
	);

endmodule

/* tb_camera_control_asserts.sv */
`timescale 1ns/1ps

module tb_camera_control_asserts (
	input logic                     clk_25,
	input logic                     rst,
	input logic                     done,
	input logic                     scl,
	input logic                     sda,
	input logic                     sda_oe,
	input cam_cfg_pkg::sccb_phase_t phase
);

	int assert_fails = 0;

	// done is a single-cycle pulse
	done_one_cycle: assert property (@(posedge clk_25) disable iff (!rst)
		done |=> !done)
		else
		begin
			$error("done held high for more than one cycle");
			assert_fails++;
		end

	// Bus idle, the sda enable lags the phase by one cycle
	idle_bus_free: assert property (@(posedge clk_25) disable iff (!rst)
		(phase == cam_cfg_pkg::PH_IDLE && $past(phase) == cam_cfg_pkg::PH_IDLE)
		|-> (scl && !sda_oe))
		else
		begin
			$error("scl low or sda driven while the master is idle");
			assert_fails++;
		end

	// Only start and stop may move sda with scl high
	sda_stable_scl_high: assert property (@(posedge clk_25) disable iff (!rst)
		(scl && $past(scl) && phase != cam_cfg_pkg::PH_START &&
		phase != cam_cfg_pkg::PH_STOP) |-> $stable(sda))
		else
		begin
			$error("sda changed while scl was high outside start or stop");
			assert_fails++;
		end

endmodule

/* tb_sccb_checker.sv */
`timescale 1ns/1ps

module tb_sccb_checker (
	input  logic               clk_25,
	input  logic               rst,
	input  logic               scl,
	inout  wire                sda,
	input  logic               configure_over,
	input  cam_cfg_pkg::byte_t cam_id,
	input  logic               armed,
	input  cam_cfg_pkg::byte_t run_id,
	output int                 runs_done,
	output int                 xact_total,
	output int                 pass_count,
	output int                 fail_count
);

	typedef struct packed {
		logic [1:0]         len;
		cam_cfg_pkg::byte_t dev;
		cam_cfg_pkg::byte_t sub;
		cam_cfg_pkg::byte_t data;
	} xact_t;

	cam_cfg_pkg::byte_t bytes [4];
	cam_cfg_pkg::byte_t cur;
	logic prev_scl;
	logic prev_sda;
	logic in_frame;
	logic rd_mode;
	logic sens_oe;
	logic sens_val;
	logic pending;
	logic seen_over;
	logic over_err;
	logic idle_bad;
	logic idle_done;
	int   bit_cnt;
	int   wait_cnt;

	assign sda = sens_oe ? sens_val : 1'bz;

	// ======================================================================
	// Expected transaction n of a run
	// ======================================================================

	function automatic xact_t expected_xact(input int n, input cam_cfg_pkg::byte_t id);
		xact_t x;
		case (n)
			0:  x = '{2'd3, 8'h60, 8'h12, 8'h80};
			1:  x = '{2'd3, 8'h60, 8'h11, 8'h80};
			2:  x = '{2'd3, 8'h60, 8'h6a, 8'h3e};
			3:  x = '{2'd3, 8'h60, 8'h3b, 8'h09};
			4:  x = '{2'd3, 8'h60, 8'h13, 8'he0};
			5:  x = '{2'd3, 8'h60, 8'h01, 8'h80};
			6:  x = '{2'd3, 8'h60, 8'h02, 8'h80};
			7:  x = '{2'd3, 8'h60, 8'h00, 8'h00};
			8:  x = '{2'd3, 8'h60, 8'h10, 8'h00};
			9:  x = '{2'd3, 8'h60, 8'h13, 8'he5};
			10: x = '{2'd3, 8'h60, 8'h39, 8'h50};
			11: x = '{2'd3, 8'h60, 8'h38, 8'h93};
			12: x = '{2'd3, 8'h60, 8'h37, 8'h81};
			13: x = '{2'd3, 8'h60, 8'h35, 8'h91};
			14: x = '{2'd3, 8'h60, 8'h0e, 8'h20};
			15: x = '{2'd3, 8'h60, 8'h1e, 8'h04};
			16: x = '{2'd2, 8'h60, 8'h18, 8'h00};
			// Read byte is whatever the sensor model sent
			default: x = '{2'd2, 8'h61, id, 8'h00};
		endcase
		return x;
	endfunction

	task automatic compare_xact();
		xact_t exp;
		int    nb;
		int    n;
		logic  ok;
		n = xact_total % 18;
		exp = expected_xact(n, run_id);
		nb = bit_cnt / 9;
		ok = 1'b1;
		if (nb != exp.len)
		begin
			$display("ERR @%0t: transaction %0d byte count exp %0d got %0d",
				$time, n, exp.len, nb);
			ok = 1'b0;
		end
		if (bytes[0] !== exp.dev)
		begin
			$display("ERR @%0t: transaction %0d device exp %h got %h",
				$time, n, exp.dev, bytes[0]);
			ok = 1'b0;
		end
		if (nb >= 2 && bytes[1] !== exp.sub)
		begin
			$display("ERR @%0t: transaction %0d second byte exp %h got %h",
				$time, n, exp.sub, bytes[1]);
			ok = 1'b0;
		end
		if (exp.len == 2'd3 && nb >= 3 && bytes[2] !== exp.data)
		begin
			$display("ERR @%0t: transaction %0d data exp %h got %h",
				$time, n, exp.data, bytes[2]);
			ok = 1'b0;
		end
		$display("Transaction %0d of run %0d: %s", n, runs_done + 1, ok ? "PASS" : "FAIL");
		if (ok)
			pass_count++;
		else
			fail_count++;
		if (n == 17)
		begin
			pending = 1'b1;
			wait_cnt = 0;
		end
		xact_total++;
	endtask

	// ======================================================================
	// Bus decoder, sensor model and output checks
	// ======================================================================

	always @(negedge clk_25 or negedge rst)
	begin
		logic now_scl;
		logic now_sda;
		now_scl = scl;
		now_sda = sda;
		if (!rst)
		begin
			in_frame = 1'b0;
			rd_mode = 1'b0;
			sens_oe = 1'b0;
			sens_val = 1'b1;
			pending = 1'b0;
			seen_over = 1'b0;
			over_err = 1'b0;
			idle_bad = 1'b0;
			idle_done = 1'b0;
			bit_cnt = 0;
			runs_done = 0;
			xact_total = 0;
			pass_count = 0;
			fail_count = 0;
		end
		else
		begin
			// Quiet bus and cleared outputs before the first press
			if (!armed)
			begin
				if (!idle_bad && (now_scl !== 1'b1 || now_sda !== 1'b1 ||
					configure_over !== 1'b0 || cam_id !== 8'h00))
				begin
					idle_bad = 1'b1;
					$display("ERR @%0t: not idle, scl %b sda %b configure_over %b cam_id %h",
						$time, now_scl, now_sda, configure_over, cam_id);
				end
			end
			else if (!idle_done)
			begin
				idle_done = 1'b1;
				$display("Idle state after reset: %s", idle_bad ? "FAIL" : "PASS");
				if (idle_bad)
					fail_count++;
				else
					pass_count++;
			end

			if (configure_over === 1'b1)
				seen_over = 1'b1;
			else if (seen_over && !over_err)
			begin
				over_err = 1'b1;
				$display("ERR @%0t: configure_over fell after being set", $time);
				fail_count++;
			end

			if (prev_scl === 1'b1 && now_scl === 1'b1 && prev_sda === 1'b1 && now_sda === 1'b0)
			begin
				in_frame = 1'b1;
				rd_mode = 1'b0;
				bit_cnt = 0;
			end
			else if (in_frame && prev_scl === 1'b1 && now_scl === 1'b1 &&
				prev_sda === 1'b0 && now_sda === 1'b1)
			begin
				// The scl rise of the stop counts as one spare bit
				in_frame = 1'b0;
				compare_xact();
			end
			else if (in_frame && prev_scl === 1'b0 && now_scl === 1'b1)
			begin
				if (bit_cnt % 9 < 8)
					cur = {cur[6:0], now_sda};
				if (bit_cnt % 9 == 7 && bit_cnt / 9 < 4)
					bytes[bit_cnt / 9] = cur;
				if (bit_cnt == 7 && now_sda === 1'b1)
					rd_mode = 1'b1;
				bit_cnt++;
			end
			else if (in_frame && prev_scl === 1'b1 && now_scl === 1'b0)
			begin
				// Sensor puts the ID on sda after each falling scl
				if (rd_mode && bit_cnt >= 9 && bit_cnt < 17)
				begin
					sens_oe = 1'b1;
					sens_val = run_id[16 - bit_cnt];
				end
				else
					sens_oe = 1'b0;
			end

			if (pending)
			begin
				wait_cnt++;
				if (configure_over === 1'b1 && cam_id === run_id)
				begin
					pending = 1'b0;
					$display("ID result of run %0d: PASS", runs_done + 1);
					pass_count++;
					runs_done++;
				end
				else if (wait_cnt > 300)
				begin
					pending = 1'b0;
					$display("ERR @%0t: cam_id exp %h got %h, configure_over %b",
						$time, run_id, cam_id, configure_over);
					$display("ID result of run %0d: FAIL", runs_done + 1);
					fail_count++;
					runs_done++;
				end
			end
		end
		prev_scl = now_scl;
		prev_sda = now_sda;
	end

endmodule

/* tb_camera_control.sv */
`timescale 1ns/1ps

module tb_camera_control;

	// Two runs take about 257k cycles, the idle gaps about 45k
	localparam int TIMEOUT_CYCLES = 400000;

	logic               clk_25 = 1'b0;
	logic               rst;
	logic               start_button;
	logic               armed;
	logic               scl;
	logic               configure_over;
	cam_cfg_pkg::byte_t cam_id;
	cam_cfg_pkg::byte_t run_id;
	wire                sda;
	logic [31:0]        seed;
	int                 runs_done;
	int                 xact_total;
	int                 pass_count;
	int                 fail_count;
	int                 count_fail;
	int                 cycle_cnt = 0;

	pullup (sda);

	camera_control u_dut (
		.clk_25         (clk_25),
		.rst            (rst),
		.start_button   (start_button),
		.scl            (scl),
		.sda            (sda),
		.configure_over (configure_over),
		.cam_id         (cam_id)
	);

	tb_sccb_checker u_checker (
		.clk_25         (clk_25),
		.rst            (rst),
		.scl            (scl),
		.sda            (sda),
		.configure_over (configure_over),
		.cam_id         (cam_id),
		.armed          (armed),
		.run_id         (run_id),
		.runs_done      (runs_done),
		.xact_total     (xact_total),
		.pass_count     (pass_count),
		.fail_count     (fail_count)
	);

	bind sccb_master tb_camera_control_asserts u_asserts (
		.clk_25 (clk_25),
		.rst    (rst),
		.done   (done),
		.scl    (scl),
		.sda    (sda),
		.sda_oe (sda_oe),
		.phase  (phase)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic press_button(input int hold);
		@(negedge clk_25);
		start_button = 1'b1;
		repeat (hold) @(negedge clk_25);
		start_button = 1'b0;
	endtask

	always #2 clk_25 = ~clk_25;

	always @(posedge clk_25)
	begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	initial
	begin
		rst = 1'b0;
		start_button = 1'b0;
		armed = 1'b0;
		run_id = 8'h00;
		count_fail = 0;
		seed = 32'h668c;
		repeat (4) @(posedge clk_25);
		@(negedge clk_25);
		rst = 1'b1;
		repeat (2000) @(negedge clk_25);

		// ==================================================================
		// First run, long press plus a second edge mid-run
		// ==================================================================
		seed = lcg_next(seed);
		run_id = seed[23:16];
		armed = 1'b1;
		press_button(5000);
		repeat (3000) @(negedge clk_25);
		press_button(50);
		wait (runs_done == 1);

		// A run left over from the mid-run edge would start here
		repeat (20000) @(negedge clk_25);
		if (xact_total != 18)
		begin
			$display("Wrong number of transactions after run 1: expected 18, saw %0d",
				xact_total);
			count_fail++;
		end

		// ==================================================================
		// Second run with a new ID, button held past the end of the run
		// ==================================================================
		@(negedge clk_25);
		seed = lcg_next(seed);
		run_id = seed[23:16];
		start_button = 1'b1;
		wait (runs_done == 2);
		repeat (1000) @(negedge clk_25);
		start_button = 1'b0;

		// Longer than one transaction, so a stray one would show up
		repeat (20000) @(negedge clk_25);
		if (xact_total != 36)
		begin
			$display("Wrong number of transactions: expected 36, saw %0d", xact_total);
			count_fail++;
		end
		if (u_dut.u_master.u_asserts.assert_fails != 0)
		begin
			$display("Bus assertions failed %0d times",
				u_dut.u_master.u_asserts.assert_fails);
			count_fail++;
		end
		$display("Tests: %0d passed, %0d failed", pass_count, fail_count + count_fail);
		if (fail_count == 0 && count_fail == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* build.f */
cam_cfg_pkg.sv
cam_cfg_rom.sv
sccb_master.sv
cam_cfg_sequencer.sv
camera_control.sv
tb_camera_control_asserts.sv
tb_sccb_checker.sv
tb_camera_control.sv

/* Bender.yml */
package:
  name: camera_control

sources:
  - files:
      - cam_cfg_pkg.sv
      - cam_cfg_rom.sv
      - sccb_master.sv
      - cam_cfg_sequencer.sv
      - camera_control.sv
  - target: test
    files:
      - tb_camera_control_asserts.sv
      - tb_sccb_checker.sv
      - tb_camera_control.sv
